//--- Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = lz_match_tile_tb
FILELIST   = tb.f
BUILD_DIR  = obj_dir
PASS_MSG   = Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the run passes only if the pass line shows up in the simulator output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- source/lz_history_window.sv
// sliding history window
`timescale 1ns/1ns
`default_nettype none

module lz_history_window
   import lz_tile_pkg::*;
   #(
      parameter int HIST_DEPTH = 16
   )
   (
      input  wire                                          clk,
      input  wire                                          rst_n,
      input  byte_t                                        byte_in,
      input  wire                                          byte_vld,
      input  wire                                          clr,
      output byte_t [HIST_DEPTH+lookahead_len-1:0]         win_data,
      output logic  [HIST_DEPTH+lookahead_len-1:0]         win_vld,
      output logic                                         win_new
   );

   localparam int WIN_SLOTS = HIST_DEPTH + lookahead_len;

   // ************************************************************
   // valid bits and evaluate strobe
   // ************************************************************

   // slot 0 holds the newest byte, valid bits stay contiguous from slot 0
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         win_vld <= '0;
         win_new <= 1'b0;
      end else begin
         win_new <= byte_vld;                                   // banks evaluate next cycle
         if (clr) begin
            win_vld <= {{(WIN_SLOTS-1){1'b0}}, byte_vld};       // same-edge byte survives
         end else if (byte_vld) begin
            win_vld <= {win_vld[WIN_SLOTS-2:0], 1'b1};
         end
      end
   end

   // ************************************************************
   // byte shift register
   // ************************************************************

   always_ff @(posedge clk) begin
      if (byte_vld) begin
         win_data <= {win_data[WIN_SLOTS-2:0], byte_in};        // oldest byte drops off
      end
   end

endmodule

`default_nettype wire

//--- source/lz_match_select.sv
// near and far match selector
`timescale 1ns/1ns
`default_nettype none

module lz_match_select
   import lz_tile_pkg::*;
   (
      input  wire          clk,
      input  wire          rst_n,
      input  bank_result_t near_res,
      input  bank_result_t far_res,
      input  wire          res_vld,
      input  byte_t        literal,
      input  tile_mode_e   mode,
      output tile_match_t  match
   );

   tile_mode_e   mode_d;                        // mode of the byte just shifted in
   tile_mode_e   mode_s;                        // aligned with the bank results
   byte_t        lit_s;
   bank_result_t pick;

   // ************************************************************
   // input capture
   // ************************************************************

   // mode is delayed once so it is captured next to the bank stage,
   // the literal is taken from the window when the banks evaluate
   always_ff @(posedge clk) begin
      mode_d <= mode;
      mode_s <= mode_d;
      lit_s  <= literal;
   end

   // ************************************************************
   // bank choice
   // ************************************************************

   always_comb begin
      case (mode_s)
         TILE_FULL: begin
            if (far_res.found && (far_res.len > near_res.len)) begin
               pick = far_res;                  // far wins only if strictly longer
            end else begin
               pick = near_res;
            end
         end
         TILE_NEAR: pick = near_res;
         default:   pick = '0;                  // literals only
      endcase
   end

   // ************************************************************
   // output register
   // ************************************************************

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         match.vld <= 1'b0;
      end else begin
         match.vld <= res_vld;
         if (res_vld) begin
            match.literal <= lit_s;
            if (pick.found) begin
               match.is_match <= 1'b1;
               match.len      <= pick.len;
               match.offset   <= pick.offset;
            end else begin
               match.is_match <= 1'b0;
               match.len      <= '0;
               match.offset   <= '0;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- source/lz_match_tile.sv
// lz77 match tile
`timescale 1ns/1ns
`default_nettype none

module lz_match_tile
   import lz_tile_pkg::*;
   #(
      parameter int HIST_DEPTH = 16            // even, at most 32
   )
   (
      input  wire         clk,
      input  wire         rst_n,
      input  byte_t       byte_in,
      input  wire         byte_vld,
      input  wire         clr,
      input  tile_mode_e  mode,
      output tile_match_t match
   );

   localparam int BANK_DEPTH = HIST_DEPTH / 2;
   localparam int NEAR_BASE  = 1;
   localparam int FAR_BASE   = BANK_DEPTH + 1;
   localparam int WIN_SLOTS  = HIST_DEPTH + lookahead_len;
   localparam int NEAR_SLOTS = NEAR_BASE + BANK_DEPTH + lookahead_len - 1;

   byte_t [WIN_SLOTS-1:0] win_data;
   logic  [WIN_SLOTS-1:0] win_vld;
   logic                  win_new;
   bank_result_t          near_res;
   bank_result_t          far_res;
   logic                  res_vld;

   lz_history_window #(
      .HIST_DEPTH (HIST_DEPTH)
   ) i_window (
      .clk      (clk),
      .rst_n    (rst_n),
      .byte_in  (byte_in),
      .byte_vld (byte_vld),
      .clr      (clr),
      .win_data (win_data),
      .win_vld  (win_vld),
      .win_new  (win_new)
   );

   // near bank sees only the slots its offsets reach
   lz_offset_bank #(
      .BASE_OFFSET (NEAR_BASE),
      .BANK_DEPTH  (BANK_DEPTH)
   ) i_near_bank (
      .clk      (clk),
      .rst_n    (rst_n),
      .win_data (win_data[NEAR_SLOTS-1:0]),
      .win_vld  (win_vld[NEAR_SLOTS-1:0]),
      .win_new  (win_new),
      .res      (near_res),
      .res_vld  (res_vld)
   );

   lz_offset_bank #(
      .BASE_OFFSET (FAR_BASE),
      .BANK_DEPTH  (BANK_DEPTH)
   ) i_far_bank (
      .clk      (clk),
      .rst_n    (rst_n),
      .win_data (win_data),
      .win_vld  (win_vld),
      .win_new  (win_new),
      .res      (far_res),
      .res_vld  ()                              // same strobe as the near bank
   );

   lz_match_select i_select (
      .clk      (clk),
      .rst_n    (rst_n),
      .near_res (near_res),
      .far_res  (far_res),
      .res_vld  (res_vld),
      .literal  (win_data[lookahead_len-1]),    // lookahead byte 0
      .mode     (mode),
      .match    (match)
   );

endmodule

`default_nettype wire

//--- source/lz_offset_bank.sv
// lz offset bank
`timescale 1ns/1ns
`default_nettype none

module lz_offset_bank
   import lz_tile_pkg::*;
   #(
      parameter int BASE_OFFSET = 1,
      parameter int BANK_DEPTH  = 8
   )
   (
      input  wire                                                   clk,
      input  wire                                                   rst_n,
      input  byte_t [BASE_OFFSET+BANK_DEPTH+lookahead_len-2:0]      win_data,
      input  wire   [BASE_OFFSET+BANK_DEPTH+lookahead_len-2:0]      win_vld,
      input  wire                                                   win_new,
      output bank_result_t                                          res,
      output logic                                                  res_vld
   );

   logic [len_w-1:0]    len_at [BANK_DEPTH];    // leading-equal count per offset
   logic [len_w-1:0]    best_len;
   logic [offset_w-1:0] best_off;
   logic                la_full;
   bank_result_t        res_nxt;

   assign la_full = &win_vld[lookahead_len-1:0];

   // ************************************************************
   // per-offset leading-equal count
   // ************************************************************

   // lookahead byte k sits in slot lookahead_len-1-k, its partner at
   // offset d sits d slots further back, so overlapping runs compare
   // against lookahead bytes themselves
   always_comb begin
      logic             run;
      logic [len_w-1:0] cnt;
      int               ref_slot;
      int               hist_slot;
      for (int i = 0; i < BANK_DEPTH; i++) begin
         run = 1'b1;
         cnt = '0;
         for (int k = 0; k < lookahead_len; k++) begin
            ref_slot  = lookahead_len - 1 - k;
            hist_slot = ref_slot + BASE_OFFSET + i;
            if (run && win_vld[hist_slot] &&
                (win_data[hist_slot] == win_data[ref_slot])) begin
               cnt = cnt + len_w'(1);
            end else begin
               run = 1'b0;                      // count stops at first mismatch
            end
         end
         len_at[i] = cnt;
      end
   end

   // ************************************************************
   // best offset in range
   // ************************************************************

   // strict compare keeps the smallest offset among equal lengths
   always_comb begin
      best_len = '0;
      best_off = '0;
      for (int i = 0; i < BANK_DEPTH; i++) begin
         if (len_at[i] > best_len) begin
            best_len = len_at[i];
            best_off = offset_w'(BASE_OFFSET + i);
         end
      end
   end

   always_comb begin
      res_nxt = '0;
      if (best_len >= min_match) begin
         res_nxt.found  = 1'b1;
         res_nxt.len    = best_len;
         res_nxt.offset = best_off;
      end
   end

   // ************************************************************
   // result register
   // ************************************************************

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         res_vld <= 1'b0;
      end else begin
         res_vld <= win_new & la_full;          // position complete
      end
   end

   always_ff @(posedge clk) begin
      if (win_new) begin
         res <= res_nxt;
      end
   end

endmodule

`default_nettype wire

//--- source/lz_tile_pkg.sv
// lz match tile definitions
`default_nettype none

package lz_tile_pkg;

   // ************************************************************
   // tile constants
   // ************************************************************

   localparam int lookahead_len = 4;            // bytes compared per position
   localparam int offset_w      = 6;            // offset field, depth up to 32
   localparam int len_w         = 3;            // length field, holds 0..4

   localparam logic [len_w-1:0] min_match = len_w'(3);  // shortest reported match

   // ************************************************************
   // data types
   // ************************************************************

   typedef logic [7:0] byte_t;

   // tile mode, sampled with each input byte
   typedef enum logic [1:0] {
      TILE_OFF  = 2'd0,                         // literals only
      TILE_FULL = 2'd1,                         // near and far banks
      TILE_NEAR = 2'd2                          // far bank ignored
   } tile_mode_e;

   // best match of one offset bank
   typedef struct packed {
      logic                found;
      logic [len_w-1:0]    len;
      logic [offset_w-1:0] offset;
   } bank_result_t;

   // tile output record
   typedef struct packed {
      logic                vld;
      logic                is_match;
      logic [len_w-1:0]    len;                 // 0 for a literal
      logic [offset_w-1:0] offset;              // 0 for a literal
      byte_t               literal;             // lookahead byte 0
   } tile_match_t;

endpackage

`default_nettype wire

//--- tb.f
source/lz_tile_pkg.sv
source/lz_history_window.sv
source/lz_offset_bank.sv
source/lz_match_select.sv
source/lz_match_tile.sv
tests/lz_match_tile_properties.sv
tests/lz_match_tile_tb.sv

//--- tests/lz_match_tile_properties.sv
// lz match tile output assertions
`timescale 1ns/1ns
`default_nettype none

module lz_match_tile_properties
   import lz_tile_pkg::*;
   #(
      parameter int HIST_DEPTH = 16
   )
   (
      input wire         clk,
      input wire         rst_n,
      input wire         byte_vld,
      input tile_match_t match
   );

   // ************************************************************
   // output record rules
   // ************************************************************

   a_idle_after_reset : assert property (@(posedge clk) !rst_n |=> !match.vld)
      else $error("match.vld high in the cycle after reset");

   a_match_fields : assert property (@(posedge clk) disable iff (!rst_n)
         (match.vld && match.is_match) |->
            (match.len >= min_match) && (match.offset >= offset_w'(1)) &&
            (match.offset <= offset_w'(HIST_DEPTH)))
      else $error("match record with bad length or offset");

   a_literal_fields : assert property (@(posedge clk) disable iff (!rst_n)
         (match.vld && !match.is_match) |-> (match.len == '0) && (match.offset == '0))
      else $error("literal record with nonzero length or offset");

   // byte sampled at edge N shows as match.vld at edge N+3
   a_vld_follows_byte : assert property (@(posedge clk) disable iff (!rst_n)
         match.vld |-> $past(byte_vld, 3))
      else $error("match.vld without a byte two cycles earlier");

endmodule

bind lz_match_tile lz_match_tile_properties #(
   .HIST_DEPTH (HIST_DEPTH)
) i_properties (
   .clk      (clk),
   .rst_n    (rst_n),
   .byte_vld (byte_vld),
   .match    (match)
);

`default_nettype wire

//--- tests/lz_match_tile_tb.sv
// lz match tile testbench
`timescale 1ns/1ns
`default_nettype none

module lz_match_tile_tb
   import lz_tile_pkg::*;
   ();

   localparam int hist_depth = 16;
   localparam int bank_depth = hist_depth / 2;
   localparam int fill_len   = 6;
   localparam int rand_len   = 300;
   localparam int mode_len   = 100;
   localparam int clr_len    = 60;
   localparam int drain_len  = 8;

   logic        clk;
   logic        rst_n;
   byte_t       byte_in;
   logic        byte_vld;
   logic        clr;
   tile_mode_e  mode;
   tile_match_t match;

   byte_t       stream_q [$];                  // every accepted byte
   int          seg_q    [$];                  // oldest usable index per byte
   tile_mode_e  mode_q   [$];
   tile_match_t exp_q    [$];
   bit          vld_due  [0:4095];             // cycles in which match.vld is due
   string       planted  [6];
   logic [31:0] rand_state;
   int          cur_seg;
   int          cyc = 0;
   int          cycle_limit = 1 << 30;

   lz_match_tile #(
      .HIST_DEPTH (hist_depth)
   ) i_dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .byte_in  (byte_in),
      .byte_vld (byte_vld),
      .clr      (clr),
      .mode     (mode),
      .match    (match)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) begin
      cyc = cyc + 1;
      if (cyc > cycle_limit) begin
         $display("timeout, the run did not end within %0d cycles", cycle_limit);
         stop_on_error();
      end
   end

   // ************************************************************
   // reference model
   // ************************************************************

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // leading-equal count at offset d, never reaching behind the last clear
   function automatic int run_length(input int n, input int d);
      int cnt;
      int idx;
      int la;
      cnt = 0;
      for (int k = 0; k < lookahead_len; k++) begin
         la  = n - (lookahead_len - 1) + k;
         idx = la - d;
         if (cnt == k && idx >= seg_q[n] && stream_q[idx] == stream_q[la]) begin
            cnt++;
         end
      end
      return cnt;
   endfunction

   function automatic tile_match_t expected_match(input int n);
      tile_match_t r;
      int          len;
      int          near_len;
      int          near_off;
      int          far_len;
      int          far_off;
      int          pick_len;
      int          pick_off;
      near_len = 0;
      near_off = 0;
      far_len  = 0;
      far_off  = 0;
      for (int d = 1; d <= hist_depth; d++) begin
         len = run_length(n, d);
         if (d <= bank_depth) begin
            if (len > near_len) begin
               near_len = len;                 // strict, smallest offset kept
               near_off = d;
            end
         end else if (len > far_len) begin
            far_len = len;
            far_off = d;
         end
      end
      if (near_len < int'(min_match)) near_len = 0;
      if (far_len < int'(min_match)) far_len = 0;
      pick_len = 0;
      pick_off = 0;
      if (mode_q[n] == TILE_FULL && far_len > near_len) begin
         pick_len = far_len;
         pick_off = far_off;
      end else if (mode_q[n] == TILE_FULL || mode_q[n] == TILE_NEAR) begin
         pick_len = near_len;
         pick_off = near_off;
      end
      r         = '0;
      r.vld     = 1'b1;
      r.literal = stream_q[n - (lookahead_len - 1)];
      if (pick_len != 0) begin
         r.is_match = 1'b1;
         r.len      = len_w'(pick_len);
         r.offset   = offset_w'(pick_off);
      end
      return r;
   endfunction

   // ************************************************************
   // checks
   // ************************************************************

   task automatic stop_on_error();
      $display("Test FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic compare_match(input tile_match_t exp, input tile_match_t act);
      if (act !== exp) begin
         $display("** Error at %0t ns: match = %h, expected %h", $time, act, exp);
         stop_on_error();
      end
   endtask

   task automatic compare_vld(input logic exp, input logic act);
      if (act !== exp) begin
         $display("** Error at %0t ns: match.vld = %b, expected %b", $time, act, exp);
         stop_on_error();
      end
   endtask

   // outputs are sampled at the falling edge, away from the register updates
   initial begin
      tile_match_t exp_rec;
      wait (rst_n === 1'b1);
      forever begin
         @(negedge clk);
         compare_vld(logic'(vld_due[cyc]), match.vld);
         if (match.vld) begin
            if (exp_q.size() == 0) begin
               $display("match.vld high at %0t ns with no expected result left", $time);
               stop_on_error();
            end else begin
               exp_rec = exp_q.pop_front();
               compare_match(exp_rec, match);
            end
         end
      end
   end

   // ************************************************************
   // stimulus
   // ************************************************************

   task automatic drive_cycle(input logic vld, input byte_t b, input tile_mode_e m,
                              input logic c);
      int n;
      @(posedge clk);
      #1;
      byte_vld = vld;
      byte_in  = b;
      mode     = m;
      clr      = c;
      if (c) cur_seg = stream_q.size();        // same-edge byte starts the new segment
      if (vld) begin
         stream_q.push_back(b);
         seg_q.push_back(cur_seg);
         mode_q.push_back(m);
         n = stream_q.size() - 1;
         if (n - cur_seg >= lookahead_len - 1) begin
            exp_q.push_back(expected_match(n));
            vld_due[cyc + 3] = 1'b1;           // sampled next edge, out two edges later
         end
      end
   endtask

   task automatic send_random(input int count, input tile_mode_e m);
      logic  vld;
      byte_t b;
      for (int i = 0; i < count; i++) begin
         rand_state = lcg_step(rand_state);
         vld = (rand_state[26:24] < 3'd5);      // bursts with gaps
         b   = 8'h61 + {6'd0, rand_state[17:16]};  // four letters only
         drive_cycle(vld, b, m, 1'b0);
      end
   endtask

   task automatic send_text(input string s, input tile_mode_e m);
      drive_cycle(1'b0, 8'h00, m, 1'b1);
      for (int i = 0; i < s.len(); i++) begin
         drive_cycle(1'b1, byte_t'(s[i]), m, 1'b0);
      end
   endtask

   initial begin
      rst_n      = 1'b0;
      byte_in    = 8'h00;
      byte_vld   = 1'b0;
      clr        = 1'b0;
      mode       = TILE_FULL;
      rand_state = 32'h9ca7;
      cur_seg    = 0;
      planted[0] = "abcdeabcd";                // near bank, offset 5
      planted[1] = "mnopqrstuvwxyzmnop";       // far bank, offset 14
      planted[2] = "wxyzghjwxyzwxyz";          // length 4 at offsets 4 and 11
      planted[3] = "qqqqqqqqq";                // overlapping run
      planted[4] = "abcabcabcabc";
      planted[5] = "ijkmABCDEFGHIijkn";        // far bank, length 3
      cycle_limit = 2 + fill_len + rand_len + 2 * mode_len + 3 * clr_len + 2 + drain_len + 50;
      foreach (planted[i]) cycle_limit += planted[i].len() + 1;
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;
      for (int i = 0; i < fill_len; i++) begin
         drive_cycle(1'b1, byte_t'(8'h30 + i), TILE_FULL, 1'b0);
      end
      send_random(rand_len, TILE_FULL);
      foreach (planted[i]) send_text(planted[i], TILE_FULL);
      send_random(mode_len, TILE_NEAR);
      send_random(mode_len, TILE_OFF);
      send_random(clr_len, TILE_FULL);
      drive_cycle(1'b1, 8'h61, TILE_FULL, 1'b1);   // clear with a byte on the same edge
      send_random(clr_len, TILE_FULL);
      drive_cycle(1'b0, 8'h00, TILE_FULL, 1'b1);
      send_random(clr_len, TILE_FULL);
      for (int i = 0; i < drain_len; i++) begin
         drive_cycle(1'b0, 8'h00, TILE_FULL, 1'b0);
      end
      if (exp_q.size() != 0) begin
         $display("%0d expected results never came out of the DUT", exp_q.size());
         stop_on_error();
      end else begin
         $display("Test OK");
         $finish;
      end
   end

endmodule

`default_nettype wire
